// ==== rtl/core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int word_bits = 32;
    localparam int reg_addr_bits = 5;

    typedef logic [word_bits-1:0] word_t;
    typedef logic [reg_addr_bits-1:0] reg_addr_t;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // funct codes under op_special
    localparam logic [5:0] fn_sll     = 6'h00;
    localparam logic [5:0] fn_syscall = 6'h0c;
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_subu    = 6'h23;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_slt     = 6'h2a;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_sll,
        alu_lui
    } alu_op_e;

    // where an execute operand comes from
    typedef enum logic [1:0] {
        fwd_rf,
        fwd_mem,
        fwd_wb
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    halt;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm;
        logic [4:0] shamt;
        reg_addr_t dest;
        fwd_sel_e  fwd_a;
        fwd_sel_e  fwd_b;
    } id_ex_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      halt;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        logic      halt;
        reg_addr_t dest;
        word_t     wdata;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_unit #(
    parameter int imem_words = 64
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          run,
    input  logic                          stall,
    input  logic                          halt_seen,
    input  logic                          imem_we,
    input  logic [$clog2(imem_words)-1:0] imem_addr,
    input  core_pkg::word_t               imem_word,
    output core_pkg::word_t               inst,
    output logic                          inst_valid
);

    core_pkg::word_t imem [imem_words];
    logic [$clog2(imem_words)-1:0] pc;
    logic stopped;
    logic advance;
    logic take;

    // IF/ID moves only while running and not stalled
    assign advance = run && !stall;
    // no new slot once a syscall has been decoded
    assign take = advance && !halt_seen && !stopped;

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            inst_valid <= 1'b0;
            stopped <= 1'b0;
        end else if (advance) begin
            inst_valid <= take;
            if (take) begin
                pc <= pc + 1'b1;
            end else begin
                stopped <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            inst <= imem[pc];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/inst_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_decoder (
    input  core_pkg::word_t     inst,
    input  logic                inst_valid,
    output core_pkg::reg_addr_t rs,
    output core_pkg::reg_addr_t rt,
    output core_pkg::reg_addr_t dest,
    output core_pkg::word_t     imm,
    output logic [4:0]          shamt,
    output core_pkg::ctrl_t     ctrl
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [15:0] imm16;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];
    assign imm16  = inst[15:0];
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign shamt  = inst[10:6];

    always_comb begin
        ctrl = '0;
        dest = inst[15:11];
        imm = {{16{imm16[15]}}, imm16};
        if (inst_valid) begin
            if (opcode == core_pkg::op_special) begin
                ctrl.reg_write = 1'b1;
                case (funct)
                    core_pkg::fn_addu: ctrl.alu_op = core_pkg::alu_add;
                    core_pkg::fn_subu: ctrl.alu_op = core_pkg::alu_sub;
                    core_pkg::fn_and:  ctrl.alu_op = core_pkg::alu_and;
                    core_pkg::fn_or:   ctrl.alu_op = core_pkg::alu_or;
                    core_pkg::fn_slt:  ctrl.alu_op = core_pkg::alu_slt;
                    core_pkg::fn_sll:  ctrl.alu_op = core_pkg::alu_sll;
                    core_pkg::fn_syscall: begin
                        // syscall only halts
                        ctrl.reg_write = 1'b0;
                        ctrl.halt = 1'b1;
                    end
                    default: ctrl.reg_write = 1'b0;
                endcase
            end else begin
                // immediate forms target rt
                dest = inst[20:16];
                ctrl.use_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                case (opcode)
                    core_pkg::op_addiu: ctrl.alu_op = core_pkg::alu_add;
                    core_pkg::op_andi: begin
                        ctrl.alu_op = core_pkg::alu_and;
                        imm = {16'h0000, imm16};
                    end
                    core_pkg::op_ori: begin
                        ctrl.alu_op = core_pkg::alu_or;
                        imm = {16'h0000, imm16};
                    end
                    core_pkg::op_lui: ctrl.alu_op = core_pkg::alu_lui;
                    core_pkg::op_lw: begin
                        ctrl.alu_op = core_pkg::alu_add;
                        ctrl.mem_read = 1'b1;
                    end
                    core_pkg::op_sw: begin
                        ctrl.alu_op = core_pkg::alu_add;
                        ctrl.reg_write = 1'b0;
                        ctrl.mem_write = 1'b1;
                    end
                    default: begin
                        ctrl.use_imm = 1'b0;
                        ctrl.reg_write = 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
    input  core_pkg::reg_addr_t rs,
    input  core_pkg::reg_addr_t rt,
    input  core_pkg::ctrl_t     ctrl,
    input  core_pkg::id_ex_t    id_ex,
    input  core_pkg::ex_mem_t   ex_mem,
    output logic                load_use,
    output core_pkg::fwd_sel_e  fwd_a,
    output core_pkg::fwd_sel_e  fwd_b
);

    logic rs_used;
    logic rt_used;
    logic ex_hit_a;
    logic ex_hit_b;
    logic mem_hit_a;
    logic mem_hit_b;

    // sll and lui leave rs unread, immediate forms read rt only for stores
    assign rs_used = (ctrl.reg_write || ctrl.mem_write)
                     && ctrl.alu_op != core_pkg::alu_sll
                     && ctrl.alu_op != core_pkg::alu_lui;
    assign rt_used = (ctrl.reg_write && !ctrl.use_imm) || ctrl.mem_write;

    assign ex_hit_a = rs_used && id_ex.ctrl.reg_write && id_ex.dest != '0 && id_ex.dest == rs;
    assign ex_hit_b = rt_used && id_ex.ctrl.reg_write && id_ex.dest != '0 && id_ex.dest == rt;
    assign mem_hit_a = rs_used && ex_mem.reg_write && ex_mem.dest != '0 && ex_mem.dest == rs;
    assign mem_hit_b = rt_used && ex_mem.reg_write && ex_mem.dest != '0 && ex_mem.dest == rt;

    // load result is not ready for the very next instruction
    assign load_use = id_ex.ctrl.mem_read && (ex_hit_a || ex_hit_b);

    // nearest producer wins
    assign fwd_a = ex_hit_a ? core_pkg::fwd_mem : (mem_hit_a ? core_pkg::fwd_wb : core_pkg::fwd_rf);
    assign fwd_b = ex_hit_b ? core_pkg::fwd_mem : (mem_hit_b ? core_pkg::fwd_wb : core_pkg::fwd_rf);

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                reset,
    input  logic                we,
    input  core_pkg::reg_addr_t waddr,
    input  core_pkg::word_t     wdata,
    input  core_pkg::reg_addr_t raddr_a,
    input  core_pkg::reg_addr_t raddr_b,
    output core_pkg::word_t     rdata_a,
    output core_pkg::word_t     rdata_b,
    input  core_pkg::reg_addr_t dbg_addr,
    output core_pkg::word_t     dbg_data
);

    core_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // same-cycle write is visible to the decode stage read
    assign rdata_a = (raddr_a == '0) ? '0
                   : (we && waddr == raddr_a) ? wdata : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0
                   : (we && waddr == raddr_b) ? wdata : regs[raddr_b];

    assign dbg_data = regs[dbg_addr];

endmodule

`default_nettype wire

// ==== rtl/stage_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     bubble,
    input  logic     hold,
    input  payload_t d,
    output payload_t q
);

    // an all-zero payload is an empty slot
    always_ff @(posedge clk) begin
        if (reset) begin
            q <= '0;
        end else if (!hold) begin
            if (bubble) begin
                q <= '0;
            end else begin
                q <= d;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/exec_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
    input  core_pkg::id_ex_t  id_ex,
    input  core_pkg::word_t   fwd_ex_mem,
    input  core_pkg::word_t   fwd_mem_wb,
    output core_pkg::ex_mem_t ex_mem_next,
    input  core_pkg::ex_mem_t ex_mem,
    input  core_pkg::word_t   load_data,
    output core_pkg::mem_wb_t mem_wb_next
);

    core_pkg::word_t op_a;
    core_pkg::word_t rt_value;
    core_pkg::word_t op_b;
    core_pkg::word_t result;

    // forward selects were settled in decode
    always_comb begin
        case (id_ex.fwd_a)
            core_pkg::fwd_mem: op_a = fwd_ex_mem;
            core_pkg::fwd_wb:  op_a = fwd_mem_wb;
            default:           op_a = id_ex.rs_data;
        endcase
        case (id_ex.fwd_b)
            core_pkg::fwd_mem: rt_value = fwd_ex_mem;
            core_pkg::fwd_wb:  rt_value = fwd_mem_wb;
            default:           rt_value = id_ex.rt_data;
        endcase
    end

    assign op_b = id_ex.ctrl.use_imm ? id_ex.imm : rt_value;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            core_pkg::alu_add: result = op_a + op_b;
            core_pkg::alu_sub: result = op_a - op_b;
            core_pkg::alu_and: result = op_a & op_b;
            core_pkg::alu_or:  result = op_a | op_b;
            core_pkg::alu_slt: result = {31'd0, $signed(op_a) < $signed(op_b)};
            core_pkg::alu_sll: result = op_b << id_ex.shamt;
            core_pkg::alu_lui: result = {op_b[15:0], 16'h0000};
            default:           result = '0;
        endcase
    end

    // store data takes the forwarded rt
    assign ex_mem_next = '{
        reg_write:  id_ex.ctrl.reg_write,
        mem_read:   id_ex.ctrl.mem_read,
        mem_write:  id_ex.ctrl.mem_write,
        halt:       id_ex.ctrl.halt,
        alu_result: result,
        store_data: rt_value,
        dest:       id_ex.dest
    };

    // memory stage result select
    assign mem_wb_next = '{
        reg_write: ex_mem.reg_write,
        halt:      ex_mem.halt,
        dest:      ex_mem.dest,
        wdata:     ex_mem.mem_read ? load_data : ex_mem.alu_result
    };

endmodule

`default_nettype wire

// ==== rtl/data_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_mem #(
    parameter int dmem_words = 64
) (
    input  logic            clk,
    input  logic            we,
    input  core_pkg::word_t addr,
    input  core_pkg::word_t wdata,
    output core_pkg::word_t rdata,
    input  core_pkg::word_t dbg_addr,
    output core_pkg::word_t dbg_data
);

    localparam int addr_bits = $clog2(dmem_words);

    core_pkg::word_t mem [dmem_words];
    logic [addr_bits-1:0] index;
    logic [addr_bits-1:0] dbg_index;

    // byte address, low two bits dropped
    assign index = addr[addr_bits+1:2];
    assign dbg_index = dbg_addr[addr_bits+1:2];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
    end

    assign rdata = mem[index];
    assign dbg_data = mem[dbg_index];

endmodule

`default_nettype wire

// ==== rtl/mips_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_core #(
    parameter int imem_words = 64,
    parameter int dmem_words = 64
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          run,
    input  logic                          imem_we,
    input  logic [$clog2(imem_words)-1:0] imem_addr,
    input  core_pkg::word_t               imem_word,
    input  core_pkg::reg_addr_t           dbg_reg,
    output core_pkg::word_t               dbg_reg_data,
    input  core_pkg::word_t               dbg_mem_addr,
    output core_pkg::word_t               dbg_mem_data,
    output logic                          load_use,
    output logic                          halted
);

    core_pkg::word_t inst;
    logic inst_valid;
    core_pkg::reg_addr_t rs;
    core_pkg::reg_addr_t rt;
    core_pkg::reg_addr_t dest;
    core_pkg::word_t imm;
    logic [4:0] shamt;
    core_pkg::ctrl_t ctrl;
    core_pkg::fwd_sel_e fwd_a;
    core_pkg::fwd_sel_e fwd_b;
    core_pkg::word_t rdata_a;
    core_pkg::word_t rdata_b;
    core_pkg::word_t load_data;
    core_pkg::id_ex_t id_ex_d;
    core_pkg::id_ex_t id_ex_q;
    core_pkg::ex_mem_t ex_mem_d;
    core_pkg::ex_mem_t ex_mem_q;
    core_pkg::mem_wb_t mem_wb_d;
    core_pkg::mem_wb_t mem_wb_q;

    fetch_unit #(.imem_words(imem_words)) u_fetch (
        .clk(clk), .reset(reset), .run(run), .stall(load_use), .halt_seen(ctrl.halt),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_word(imem_word),
        .inst(inst), .inst_valid(inst_valid)
    );

    inst_decoder u_decoder (
        .inst(inst), .inst_valid(inst_valid), .rs(rs), .rt(rt), .dest(dest),
        .imm(imm), .shamt(shamt), .ctrl(ctrl)
    );

    hazard_unit u_hazard (
        .rs(rs), .rt(rt), .ctrl(ctrl), .id_ex(id_ex_q), .ex_mem(ex_mem_q),
        .load_use(load_use), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    reg_file u_regs (
        .clk(clk), .reset(reset), .we(mem_wb_q.reg_write), .waddr(mem_wb_q.dest),
        .wdata(mem_wb_q.wdata), .raddr_a(rs), .raddr_b(rt), .rdata_a(rdata_a),
        .rdata_b(rdata_b), .dbg_addr(dbg_reg), .dbg_data(dbg_reg_data)
    );

    assign id_ex_d = '{
        ctrl: ctrl, rs_data: rdata_a, rt_data: rdata_b, imm: imm,
        shamt: shamt, dest: dest, fwd_a: fwd_a, fwd_b: fwd_b
    };

    // whole pipeline pauses while run is low
    stage_reg #(.payload_t(core_pkg::id_ex_t)) u_id_ex (
        .clk(clk), .reset(reset), .bubble(load_use), .hold(!run), .d(id_ex_d), .q(id_ex_q)
    );

    exec_unit u_exec (
        .id_ex(id_ex_q), .fwd_ex_mem(ex_mem_q.alu_result), .fwd_mem_wb(mem_wb_q.wdata),
        .ex_mem_next(ex_mem_d), .ex_mem(ex_mem_q), .load_data(load_data),
        .mem_wb_next(mem_wb_d)
    );

    stage_reg #(.payload_t(core_pkg::ex_mem_t)) u_ex_mem (
        .clk(clk), .reset(reset), .bubble(1'b0), .hold(!run), .d(ex_mem_d), .q(ex_mem_q)
    );

    data_mem #(.dmem_words(dmem_words)) u_dmem (
        .clk(clk), .we(ex_mem_q.mem_write), .addr(ex_mem_q.alu_result),
        .wdata(ex_mem_q.store_data), .rdata(load_data),
        .dbg_addr(dbg_mem_addr), .dbg_data(dbg_mem_data)
    );

    stage_reg #(.payload_t(core_pkg::mem_wb_t)) u_mem_wb (
        .clk(clk), .reset(reset), .bubble(1'b0), .hold(!run), .d(mem_wb_d), .q(mem_wb_q)
    );

    // syscall has left writeback
    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (mem_wb_q.halt) begin
            halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== bench/clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module clock_gen #(
    parameter int period = 40,
    parameter int reset_cycles = 4
) (
    input  logic reset_req,
    output logic clk,
    output logic reset
);

    int remaining = reset_cycles;

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // a request starts a fresh reset of reset_cycles edges
    always @(posedge clk) begin
        if (reset_req) begin
            remaining <= reset_cycles;
        end else if (remaining != 0) begin
            remaining <= remaining - 1;
        end
    end

    assign reset = remaining != 0;

endmodule

`default_nettype wire

// ==== bench/mips_core_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_core_sva (
    input logic clk,
    input logic reset,
    input logic load_use,
    input logic halted
);

    int fail_count = 0;

    // halted is sticky until the next reset
    halted_sticky: assert property (@(posedge clk) halted && !reset |=> halted)
        else begin
            fail_count++;
            $error("halted fell without a reset");
        end

    // one bubble per load-use pair
    single_stall: assert property (@(posedge clk) disable iff (reset) load_use |=> !load_use)
        else begin
            fail_count++;
            $error("load_use stayed high for two cycles");
        end

    clean_after_reset: assert property (@(posedge clk) reset |=> !load_use && !halted)
        else begin
            fail_count++;
            $error("load_use or halted high right after reset");
        end

endmodule

`default_nettype wire

// ==== bench/tb_mips_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mips_core;

    localparam int clk_period = 40;
    localparam int imem_words = 64;
    localparam int dmem_words = 64;
    localparam string cases_path = "bench/core_cases.txt";
    // special opcode, funct 0c
    localparam logic [31:0] syscall_word = 32'h0000000c;

    // one expected register or memory word
    typedef struct packed {
        logic            is_mem;
        core_pkg::word_t addr;
        core_pkg::word_t value;
    } expect_t;

    logic clk;
    logic reset;
    logic reset_req;
    logic run;
    logic imem_we;
    logic [$clog2(imem_words)-1:0] imem_addr;
    core_pkg::word_t imem_word;
    core_pkg::reg_addr_t dbg_reg;
    core_pkg::word_t dbg_reg_data;
    core_pkg::word_t dbg_mem_addr;
    core_pkg::word_t dbg_mem_data;
    logic load_use;
    logic halted;

    string case_name[$];
    int case_stalls[$];
    int prog_first[$];
    int prog_len[$];
    int exp_first[$];
    int exp_len[$];
    core_pkg::word_t prog[$];
    expect_t expects[$];

    int mismatches = 0;
    int other_errors = 0;
    bit cases_ready = 1'b0;
    realtime watchdog_time = 0;

    clock_gen #(.period(clk_period), .reset_cycles(4)) clk0 (
        .reset_req(reset_req), .clk(clk), .reset(reset)
    );

    mips_core #(.imem_words(imem_words), .dmem_words(dmem_words)) dut0 (
        .clk(clk), .reset(reset), .run(run), .imem_we(imem_we), .imem_addr(imem_addr),
        .imem_word(imem_word), .dbg_reg(dbg_reg), .dbg_reg_data(dbg_reg_data),
        .dbg_mem_addr(dbg_mem_addr), .dbg_mem_data(dbg_mem_data),
        .load_use(load_use), .halted(halted)
    );

    bind mips_core mips_core_sva sva0 (
        .clk(clk), .reset(reset), .load_use(load_use), .halted(halted)
    );

    task automatic check_value(input string what, input core_pkg::word_t expected,
                               input core_pkg::word_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("ERR %s expected %h actual %h", what, expected, actual);
        end
    endtask

    task automatic read_cases();
        int fd;
        int code;
        int words;
        int stalls;
        int reg_index;
        string tag;
        string rest;
        string name;
        core_pkg::word_t word;
        expect_t item;
        fd = $fopen(cases_path, "r");
        if (fd == 0) begin
            other_errors++;
            $display("cannot open %s", cases_path);
            return;
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag.substr(0, 0) == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "case") begin
                code = $fscanf(fd, "%s %d %d", name, words, stalls);
                case_name.push_back(name);
                case_stalls.push_back(stalls);
                prog_first.push_back(prog.size());
                prog_len.push_back(words);
                exp_first.push_back(expects.size());
                exp_len.push_back(0);
                for (int i = 0; i < words; i++) begin
                    code = $fscanf(fd, "%h", word);
                    if (code != 1) begin
                        other_errors++;
                        $display("case %s has fewer than %0d program words", name, words);
                    end
                    prog.push_back(word);
                end
            end else if ((tag == "r" || tag == "m") && exp_len.size() != 0) begin
                item.is_mem = (tag == "m");
                if (item.is_mem) begin
                    code = $fscanf(fd, "%h %h", item.addr, item.value);
                end else begin
                    code = $fscanf(fd, "%d %h", reg_index, item.value);
                    item.addr = reg_index;
                end
                expects.push_back(item);
                exp_len[exp_len.size() - 1]++;
            end else begin
                other_errors++;
                $display("unexpected token %s in %s", tag, cases_path);
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset_req <= 1'b1;
        @(posedge clk);
        reset_req <= 1'b0;
        @(negedge clk);
        while (reset) begin
            @(negedge clk);
        end
    endtask

    task automatic load_program(input int idx);
        for (int i = 0; i < prog_len[idx]; i++) begin
            @(posedge clk);
            imem_we <= 1'b1;
            imem_addr <= i;
            imem_word <= prog[prog_first[idx] + i];
            // sometimes an idle cycle before the next word
            if ($urandom % 2 != 0) begin
                @(posedge clk);
                imem_we <= 1'b0;
            end
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    // cycles counted from the first cycle with run high
    task automatic run_to_halt(output int cycles, output int stalls);
        cycles = 0;
        stalls = 0;
        @(posedge clk);
        run <= 1'b1;
        @(negedge clk);
        while (!halted) begin
            if (load_use) begin
                stalls++;
            end
            @(negedge clk);
            cycles++;
        end
        @(posedge clk);
        run <= 1'b0;
    endtask

    task automatic read_back(input string name, input expect_t item);
        @(posedge clk);
        if (item.is_mem) begin
            dbg_mem_addr <= item.addr;
        end else begin
            dbg_reg <= item.addr[4:0];
        end
        @(negedge clk);
        if (item.is_mem) begin
            check_value($sformatf("%s mem %h", name, item.addr), item.value, dbg_mem_data);
        end else begin
            check_value($sformatf("%s r%0d", name, item.addr), item.value, dbg_reg_data);
        end
    endtask

    task automatic run_case(input int idx);
        string name;
        int syscall_at;
        int cycles;
        int stalls;
        name = case_name[idx];
        syscall_at = -1;
        for (int i = 0; i < prog_len[idx]; i++) begin
            if (syscall_at < 0 && prog[prog_first[idx] + i] == syscall_word) begin
                syscall_at = i;
            end
        end
        if (syscall_at < 0) begin
            other_errors++;
            $display("case %s has no syscall and was skipped", name);
            return;
        end
        apply_reset();
        load_program(idx);
        run_to_halt(cycles, stalls);
        check_value({name, " stalls"}, case_stalls[idx], stalls);
        // n instructions, s stalls, five stages
        check_value({name, " halt cycle"}, syscall_at + case_stalls[idx] + 5, cycles);
        for (int i = 0; i < exp_len[idx]; i++) begin
            read_back(name, expects[exp_first[idx] + i]);
        end
    endtask

    task automatic finish_run(input bit timed_out);
        int sva_fails;
        sva_fails = dut0.sva0.fail_count;
        $display("errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatches, other_errors, sva_fails);
        if (mismatches == 0 && other_errors == 0 && sva_fails == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    initial begin
        reset_req = 1'b0;
        run = 1'b0;
        imem_we = 1'b0;
        imem_addr = '0;
        imem_word = '0;
        dbg_reg = '0;
        dbg_mem_addr = '0;
        void'($urandom(32'hfe76));
        read_cases();
        if (case_name.size() == 0) begin
            other_errors++;
            $display("no cases found in %s", cases_path);
        end
        foreach (prog_len[i]) begin
            watchdog_time += (2 * prog_len[i] + 60) * clk_period;
        end
        cases_ready = 1'b1;
        foreach (case_name[i]) begin
            run_case(i);
        end
        finish_run(1'b0);
    end

    // watchdog
    initial begin
        wait (cases_ready);
        #(watchdog_time);
        $display("watchdog expired, the run timed out at %0t", $time);
        finish_run(1'b1);
    end

endmodule

`default_nettype wire

// ==== bench/core_cases.txt ====
# case <name> <word count> <stall count> followed by the program words in hex
# r <register> <expected hex>    m <byte address hex> <expected hex>
# addiu r1,5 addiu r2,-3 ori r3,f0f0 lui r4,1234 addu r5,r1,r2 subu r6,r1,r2 slt r7,r2,r1
# andi r8,r3,0ff0 or r9,r3,r4 sll r10,r1,4 addiu r0,7 and r11,r2,r3 syscall
case alu_basic 13 0
    24010005 2402fffd 3403f0f0 3c041234 00222821 00223023 0041382a
    30680ff0 00644825 00015100 24000007 00435824 0000000c
r 0 00000000 r 1 00000005 r 2 fffffffd r 3 0000f0f0 r 4 12340000 r 5 00000002
r 6 00000008 r 7 00000001 r 8 000000f0 r 9 1234f0f0 r 10 00000050 r 11 0000f0f0
# addiu r1,10 addu r2,r1,r1 addu r3,r2,r1 subu r4,r3,r1 sll r5,r3,2 or r6,r4,r5 slt r7,r4,r6
# addiu r1,r1,1 addu r8,r1,r1 addiu r9,1 addiu r9,2 addu r10,r9,r9 syscall
case forward 13 0
    2401000a 00211021 00411821 00612023 00032880 00853025 0086382a
    24210001 00214021 24090001 24090002 01295021 0000000c
r 1 0000000b r 2 00000014 r 3 0000001e r 4 00000014 r 5 00000078
r 6 0000007c r 7 00000001 r 8 00000016 r 9 00000002 r 10 00000004
# lui r1,dead ori r1,r1,beef addiu r2,40 sw r1,8(r2) sw r2,-4(r2) lw r3,8(r2) lw r4,-4(r2)
# nop addu r5,r3,r4 syscall
case store_load 10 0
    3c01dead 3421beef 24020040 ac410008 ac42fffc 8c430008 8c44fffc
    00000000 00642821 0000000c
r 1 deadbeef r 2 00000040 r 3 deadbeef r 4 00000040 r 5 deadbf2f
m 48 deadbeef m 3c 00000040
# addiu r1,20 addiu r2,7 sw r2,0(r1) lw r3,0(r1) addu r4,r3,r3 lw r5,0(r1) sw r5,4(r1)
# lw r6,4(r1) addiu r7,r6,1 lw r8,0(r1) addiu r9,3 addu r10,r8,r9 syscall addiu r11 addiu r12
case load_use 15 3
    24010020 24020007 ac220000 8c230000 00632021 8c250000 ac250004 8c260004
    24c70001 8c280000 24090003 01095021 0000000c 240b0055 240c0066
r 3 00000007 r 4 0000000e r 5 00000007 r 6 00000007 r 7 00000008 r 8 00000007
r 9 00000003 r 10 0000000a r 11 00000000 r 12 00000000 m 20 00000007 m 24 00000007

// ==== vlog.f ====
rtl/core_pkg.sv
rtl/fetch_unit.sv
rtl/inst_decoder.sv
rtl/hazard_unit.sv
rtl/reg_file.sv
rtl/stage_reg.sv
rtl/exec_unit.sv
rtl/data_mem.sv
rtl/mips_core.sv
bench/clock_gen.sv
bench/mips_core_sva.sv
bench/tb_mips_core.sv
